//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_isa_pkg.sv
      - common/cpu_ctrl_pkg.sv
      - datapath/alu.sv
      - datapath/datapath.sv
      - sequencer/sequencer.sv
      - hdl/address_unit.sv
      - hdl/cpu_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_clock.sv
      - sim/cpu_core_sva.sv
      - sim/tb_cpu_core.sv

//--- common/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	typedef logic [7:0]  data_t;
	typedef logic [15:0] addr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_func_t;

	// ALU A input
	typedef enum logic [1:0] {A_ACC, A_ZERO, A_P} a_src_t;

	// ALU B input
	typedef enum logic {B_BUS, B_ZERO} b_src_t;

	// Bus address
	typedef enum logic [1:0] {ADDR_PC, ADDR_ZP, ADDR_STACK} addr_src_t;

endpackage

//--- common/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Kept opcodes, 6502 encodings
	typedef enum logic [7:0] {
		ORA_IMM = 8'h09,
		AND_IMM = 8'h29,
		EOR_IMM = 8'h49,
		ADC_IMM = 8'h69,
		LDA_IMM = 8'hA9,
		SBC_IMM = 8'hE9,
		STA_ZP  = 8'h85,
		PHP     = 8'h08,
		CLC     = 8'h18,
		SEC     = 8'h38,
		NOP     = 8'hEA
	} opcode_t;

	// Operation group of the cc=01 instructions
	typedef enum logic [2:0] {
		GRP_ORA, GRP_AND, GRP_EOR, GRP_ADC,
		GRP_STA, GRP_LDA, GRP_CMP, GRP_SBC
	} aaa_t;

	typedef struct packed {
		aaa_t       aaa;
		logic [2:0] bbb;
		logic [1:0] cc;
	} op_fields_t;

	// Same byte, whole opcode or split into fields
	typedef union packed {
		opcode_t    op;
		op_fields_t f;
	} ins_word_t;

	typedef enum logic [1:0] {MODE_IMPLIED, MODE_IMM, MODE_ZP} addr_mode_t;

	// Only the cc=01 group carries an operand in this core
	function automatic addr_mode_t decode_mode(op_fields_t f);
		if (f.cc == 2'b01 && f.bbb == 3'b010)
			return MODE_IMM;
		if (f.cc == 2'b01 && f.bbb == 3'b001)
			return MODE_ZP;
		return MODE_IMPLIED;
	endfunction

endpackage

//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define STATUS_N 7
`define STATUS_V 6
`define STATUS_R 5
`define STATUS_B 4
`define STATUS_D 3
`define STATUS_I 2
`define STATUS_Z 1
`define STATUS_C 0

`define START_ADDR 16'h0200
`define STACK_PAGE 8'h01
`define SP_RESET   8'hFF

`endif

//--- datapath/alu.sv
`timescale 1ns/100ps

module alu (
	input  cpu_ctrl_pkg::data_t     a,
	input  cpu_ctrl_pkg::data_t     b,
	input  logic                    carry_in,
	input  cpu_ctrl_pkg::alu_func_t func,
	output cpu_ctrl_pkg::data_t     result,
	output logic                    n,
	output logic                    z,
	output logic                    c,
	output logic                    v
);

	import cpu_ctrl_pkg::*;

	data_t      b_eff;
	logic [8:0] sum;

	// Subtract as a + ~b + C, borrow is the inverted carry
	assign b_eff = (func == ALU_SUB) ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, b_eff} + {8'd0, carry_in};

	always_comb begin
		c = 1'b0;
		v = 1'b0;
		case (func)
		ALU_ADD, ALU_SUB: begin
			result = sum[7:0];
			c = sum[8];
			// Same input signs, different result sign
			v = (a[7] == b_eff[7]) && (sum[7] != a[7]);
		end
		ALU_AND: result = a & b;
		ALU_OR: result = a | b;
		ALU_XOR: result = a ^ b;
		default: result = b;
		endcase
	end

	assign n = result[7];
	assign z = (result == 8'h00);

endmodule

//--- datapath/datapath.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module datapath (
	input  logic                    sys,
	input  logic                    rst,
	input  cpu_ctrl_pkg::data_t     rdata,
	input  cpu_ctrl_pkg::a_src_t    a_sel,
	input  cpu_ctrl_pkg::b_src_t    b_sel,
	input  cpu_ctrl_pkg::alu_func_t alu_func,
	input  logic                    acc_we,
	input  logic                    store_p,
	input  logic                    sp_dec,
	input  cpu_ctrl_pkg::data_t     p_mask,
	input  cpu_ctrl_pkg::data_t     p_set,
	input  cpu_ctrl_pkg::data_t     p_clr,
	output cpu_ctrl_pkg::data_t     wdata,
	output cpu_ctrl_pkg::data_t     sp
);

	import cpu_ctrl_pkg::*;

	data_t acc, p, p_next;
	data_t alu_a, alu_b, result;
	data_t flags, status;
	logic  n, z, c, v;

	always_comb begin
		case (a_sel)
		A_ACC: alu_a = acc;
		A_P: alu_a = p;
		default: alu_a = '0;
		endcase
		alu_b = (b_sel == B_BUS) ? rdata : '0;
	end

	alu i_alu (
		.a        (alu_a),
		.b        (alu_b),
		.carry_in (p[`STATUS_C]),
		.func     (alu_func),
		.result   (result),
		.n        (n),
		.z        (z),
		.c        (c),
		.v        (v)
	);

	always_comb begin
		flags = '0;
		flags[`STATUS_N] = n;
		flags[`STATUS_V] = v;
		flags[`STATUS_Z] = z;
		flags[`STATUS_C] = c;
		// Set wins over clear, clear over the ALU flag
		for (int i = 0; i < 8; i++) begin
			if (p_set[i])
				p_next[i] = 1'b1;
			else if (p_clr[i])
				p_next[i] = 1'b0;
			else if (p_mask[i])
				p_next[i] = flags[i];
			else
				p_next[i] = p[i];
		end
	end

	always_ff @(posedge sys) begin
		if (rst) begin
			sp <= `SP_RESET;
			p <= '0;
			p[`STATUS_R] <= 1'b1;
		end else begin
			if (sp_dec)
				sp <= sp - 8'd1;
			p <= p_next;
		end
	end

	always_ff @(posedge sys) begin
		if (acc_we)
			acc <= result;
	end

	// Pushed status always shows R and B high
	always_comb begin
		status = p;
		status[`STATUS_R] = 1'b1;
		status[`STATUS_B] = 1'b1;
	end

	assign wdata = store_p ? status : acc;

endmodule

//--- hdl/address_unit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module address_unit (
	input  logic                    sys,
	input  logic                    rst,
	input  cpu_ctrl_pkg::data_t     rdata,
	input  logic                    pc_inc,
	input  logic                    ins_we,
	input  logic                    zp_we,
	input  cpu_ctrl_pkg::addr_src_t addr_sel,
	input  cpu_ctrl_pkg::data_t     sp,
	output cpu_ctrl_pkg::addr_t     addr,
	output cpu_isa_pkg::ins_word_t  ins
);

	import cpu_ctrl_pkg::*;
	import cpu_isa_pkg::*;

	addr_t pc;
	data_t zp;

	// No vector fetch, execution starts at a fixed address
	always_ff @(posedge sys) begin
		if (rst) begin
			pc <= `START_ADDR;
			ins.op <= NOP;
		end else begin
			if (pc_inc)
				pc <= pc + 16'd1;
			if (ins_we)
				ins <= rdata;
		end
	end

	always_ff @(posedge sys) begin
		if (zp_we)
			zp <= rdata;
	end

	always_comb begin
		case (addr_sel)
		ADDR_ZP: addr = {8'h00, zp};
		ADDR_STACK: addr = {`STACK_PAGE, sp};
		default: addr = pc;
		endcase
	end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
	input  logic                sys,
	input  logic                rst,
	input  cpu_ctrl_pkg::data_t rdata,
	output cpu_ctrl_pkg::addr_t addr,
	output cpu_ctrl_pkg::data_t wdata,
	output logic                oe,
	output logic                we,
	output logic                sync
);

	import cpu_ctrl_pkg::*;
	import cpu_isa_pkg::*;

	ins_word_t ins;
	logic      pc_inc, ins_we, zp_we;
	addr_src_t addr_sel;
	a_src_t    a_sel;
	b_src_t    b_sel;
	alu_func_t alu_func;
	logic      acc_we, store_p, sp_dec;
	data_t     p_mask, p_set, p_clr;
	data_t     sp;

	sequencer i_sequencer (
		.sys      (sys),
		.rst      (rst),
		.ins      (ins),
		.oe       (oe),
		.we       (we),
		.sync     (sync),
		.pc_inc   (pc_inc),
		.ins_we   (ins_we),
		.zp_we    (zp_we),
		.addr_sel (addr_sel),
		.a_sel    (a_sel),
		.b_sel    (b_sel),
		.alu_func (alu_func),
		.acc_we   (acc_we),
		.store_p  (store_p),
		.sp_dec   (sp_dec),
		.p_mask   (p_mask),
		.p_set    (p_set),
		.p_clr    (p_clr)
	);

	datapath i_datapath (
		.sys      (sys),
		.rst      (rst),
		.rdata    (rdata),
		.a_sel    (a_sel),
		.b_sel    (b_sel),
		.alu_func (alu_func),
		.acc_we   (acc_we),
		.store_p  (store_p),
		.sp_dec   (sp_dec),
		.p_mask   (p_mask),
		.p_set    (p_set),
		.p_clr    (p_clr),
		.wdata    (wdata),
		.sp       (sp)
	);

	address_unit i_address_unit (
		.sys      (sys),
		.rst      (rst),
		.rdata    (rdata),
		.pc_inc   (pc_inc),
		.ins_we   (ins_we),
		.zp_we    (zp_we),
		.addr_sel (addr_sel),
		.sp       (sp),
		.addr     (addr),
		.ins      (ins)
	);

endmodule

//--- sequencer/sequencer.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module sequencer (
	input  logic                    sys,
	input  logic                    rst,
	input  cpu_isa_pkg::ins_word_t  ins,
	output logic                    oe,
	output logic                    we,
	output logic                    sync,
	output logic                    pc_inc,
	output logic                    ins_we,
	output logic                    zp_we,
	output cpu_ctrl_pkg::addr_src_t addr_sel,
	output cpu_ctrl_pkg::a_src_t    a_sel,
	output cpu_ctrl_pkg::b_src_t    b_sel,
	output cpu_ctrl_pkg::alu_func_t alu_func,
	output logic                    acc_we,
	output logic                    store_p,
	output logic                    sp_dec,
	output cpu_ctrl_pkg::data_t     p_mask,
	output cpu_ctrl_pkg::data_t     p_set,
	output cpu_ctrl_pkg::data_t     p_clr
);

	import cpu_ctrl_pkg::*;
	import cpu_isa_pkg::*;

	enum logic [1:0] {S_RESET, S_FETCH, S_DECODE, S_EXECUTE} state, state_next;

	addr_mode_t mode;
	logic       imm_op;

	assign mode = decode_mode(ins.f);

	// Held in S_RESET while rst is high, so all strobes stay low
	always_ff @(posedge sys) begin
		if (rst)
			state <= S_RESET;
		else
			state <= state_next;
	end

	always_comb begin
		oe = 1'b0;
		we = 1'b0;
		sync = 1'b0;
		pc_inc = 1'b0;
		ins_we = 1'b0;
		zp_we = 1'b0;
		addr_sel = ADDR_PC;
		// Constant inputs when idle, less toggling in the ALU
		a_sel = A_ZERO;
		b_sel = B_ZERO;
		alu_func = ALU_PASS_B;
		acc_we = 1'b0;
		store_p = 1'b0;
		sp_dec = 1'b0;
		p_mask = '0;
		p_set = '0;
		p_clr = '0;
		imm_op = 1'b0;
		state_next = state;
		case (state)
		S_RESET: begin
			state_next = S_FETCH;
		end
		S_FETCH: begin
			oe = 1'b1;
			sync = 1'b1;
			pc_inc = 1'b1;
			ins_we = 1'b1;
			state_next = S_DECODE;
		end
		S_DECODE: begin
			state_next = S_FETCH;
			case (mode)
			MODE_IMM: begin
				case (ins.f.aaa)
				GRP_LDA: imm_op = 1'b1;
				GRP_ADC, GRP_SBC: begin
					imm_op = 1'b1;
					a_sel = A_ACC;
					// SBC borrows through C, same as the 6502
					alu_func = (ins.f.aaa == GRP_SBC) ? ALU_SUB : ALU_ADD;
					p_mask[`STATUS_C] = 1'b1;
					p_mask[`STATUS_V] = 1'b1;
				end
				GRP_AND: begin
					imm_op = 1'b1;
					a_sel = A_ACC;
					alu_func = ALU_AND;
				end
				GRP_ORA: begin
					imm_op = 1'b1;
					a_sel = A_ACC;
					alu_func = ALU_OR;
				end
				GRP_EOR: begin
					imm_op = 1'b1;
					a_sel = A_ACC;
					alu_func = ALU_XOR;
				end
				default: ;
				endcase
				// Operand read and result write share this cycle
				if (imm_op) begin
					oe = 1'b1;
					pc_inc = 1'b1;
					b_sel = B_BUS;
					acc_we = 1'b1;
					p_mask[`STATUS_N] = 1'b1;
					p_mask[`STATUS_Z] = 1'b1;
				end
			end
			MODE_ZP: begin
				if (ins.op == STA_ZP) begin
					oe = 1'b1;
					pc_inc = 1'b1;
					zp_we = 1'b1;
					state_next = S_EXECUTE;
				end
			end
			default: begin
				case (ins.op)
				PHP: begin
					we = 1'b1;
					addr_sel = ADDR_STACK;
					store_p = 1'b1;
					sp_dec = 1'b1;
				end
				CLC: p_clr[`STATUS_C] = 1'b1;
				SEC: p_set[`STATUS_C] = 1'b1;
				default: ;
				endcase
			end
			endcase
		end
		S_EXECUTE: begin
			// Zero page write of the accumulator
			we = 1'b1;
			addr_sel = ADDR_ZP;
			state_next = S_FETCH;
		end
		default: state_next = S_FETCH;
		endcase
	end

endmodule

//--- sim/cpu_core_sva.sv
`timescale 1ns/100ps

module cpu_core_sva (
	input logic sys,
	input logic rst,
	input logic oe,
	input logic we,
	input logic sync
);

	// Number of failed assertions
	int fail_count = 0;

	// Bus is never read and written in the same cycle
	property no_read_write;
		@(posedge sys) disable iff (rst) !(we && oe);
	endproperty

	property sync_reads;
		@(posedge sys) disable iff (rst) sync |-> oe;
	endproperty

	// Every instruction takes two or three cycles
	property sync_spacing;
		@(posedge sys) disable iff (rst) sync |-> ##[2:3] sync;
	endproperty

	assert property (no_read_write) else begin
		$error("oe and we high in the same cycle");
		fail_count++;
	end
	assert property (sync_reads) else begin
		$error("sync high without oe");
		fail_count++;
	end
	assert property (sync_spacing) else begin
		$error("no opcode fetch within 2 to 3 cycles of the last one");
		fail_count++;
	end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic sys,
	output logic rst
);

	// 10 ns period
	initial begin
		sys = 1'b0;
		forever #5 sys = ~sys;
	end

	// Reset covers four rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (4) @(negedge sys);
		rst = 1'b0;
	end

endmodule

//--- sim/tb_cpu_core.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_cpu_core;

	import cpu_ctrl_pkg::*;
	import cpu_isa_pkg::*;

	localparam int ROWS = 12;
	localparam int FIXED_ROWS = 6;
	// Each row runs 11 cycles (preset 2, LDA 2, op 2, STA 3, PHP 2)
	localparam int CYCLE_LIMIT = ROWS * 11 + 20;

	typedef struct packed {
		opcode_t preset;
		opcode_t op;
		data_t   a_val;
		data_t   b_val;
		data_t   zp;
		data_t   exp_acc;
		data_t   exp_p;
	} row_t;

	logic   sys, rst;
	data_t  rdata, wdata;
	addr_t  addr;
	logic   oe, we, sync;
	data_t  mem [0:65535];
	row_t   stim [ROWS];
	data_t  model_p;
	integer seed;
	int     n_writes = 0;
	int     cycles = 0;

	tb_clock i_tb_clock (
		.sys (sys),
		.rst (rst)
	);

	cpu_core i_cpu_core (
		.sys   (sys),
		.rst   (rst),
		.rdata (rdata),
		.addr  (addr),
		.wdata (wdata),
		.oe    (oe),
		.we    (we),
		.sync  (sync)
	);

	bind cpu_core cpu_core_sva i_cpu_core_sva (
		.sys  (sys),
		.rst  (rst),
		.oe   (oe),
		.we   (we),
		.sync (sync)
	);

	// Memory model read combinationally while oe is high
	assign rdata = oe ? mem[addr] : 8'h00;

	always @(posedge sys) begin
		if (we)
			mem[addr] <= wdata;
	end

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("Fail %0d ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("Fail %0d ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %0d ns: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic set_row(input int i, input opcode_t preset, input opcode_t op,
			input data_t a, input data_t b, input data_t zp);
		stim[i] = '{preset, op, a, b, zp, 8'h00, 8'h00};
	endtask

	task automatic build_table();
		logic [31:0] r;
		opcode_t     ops [6] = '{LDA_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM};
		// Overflow, carry out, borrow, signed underflow, zero, all ones
		set_row(0, CLC, ADC_IMM, 8'h7F, 8'h01, 8'h10);
		set_row(1, SEC, ADC_IMM, 8'hFF, 8'h01, 8'h11);
		set_row(2, SEC, SBC_IMM, 8'h00, 8'h01, 8'h12);
		set_row(3, CLC, SBC_IMM, 8'h80, 8'h01, 8'h13);
		set_row(4, SEC, AND_IMM, 8'hF0, 8'h0F, 8'h14);
		set_row(5, CLC, EOR_IMM, 8'hAA, 8'h55, 8'h15);
		for (int i = FIXED_ROWS; i < ROWS; i++) begin
			r = $random(seed);
			set_row(i, r[24] ? SEC : CLC, ops[r[31:28] % 6], r[7:0], r[15:8], r[23:16]);
		end
	endtask

	// 6502 flag rules with P carried over from row to row
	task automatic predict_row(input int i);
		data_t      p, a, b, res;
		logic [8:0] wide;
		p = model_p;
		a = stim[i].a_val;
		b = stim[i].b_val;
		p[`STATUS_C] = (stim[i].preset == SEC);
		case (stim[i].op)
		ADC_IMM: begin
			wide = {1'b0, a} + {1'b0, b} + {8'd0, p[`STATUS_C]};
			res = wide[7:0];
			p[`STATUS_C] = wide[8];
			p[`STATUS_V] = (a[7] == b[7]) && (res[7] != a[7]);
		end
		SBC_IMM: begin
			// Borrow is the complement of C
			wide = {1'b0, a} - {1'b0, b} - {8'd0, ~p[`STATUS_C]};
			res = wide[7:0];
			p[`STATUS_C] = ~wide[8];
			p[`STATUS_V] = (a[7] != b[7]) && (res[7] != a[7]);
		end
		AND_IMM: res = a & b;
		ORA_IMM: res = a | b;
		EOR_IMM: res = a ^ b;
		default: res = b;
		endcase
		p[`STATUS_N] = res[7];
		p[`STATUS_Z] = (res == 8'h00);
		model_p = p;
		stim[i].exp_acc = res;
		stim[i].exp_p = p;
		stim[i].exp_p[`STATUS_R] = 1'b1;
		stim[i].exp_p[`STATUS_B] = 1'b1;
	endtask

	task automatic load_program();
		addr_t base;
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h3C;
		// preset; LDA #a; op #b; STA zp; PHP
		for (int i = 0; i < ROWS; i++) begin
			base = `START_ADDR + 16'(i * 8);
			mem[base] = stim[i].preset;
			mem[base + 1] = LDA_IMM;
			mem[base + 2] = stim[i].a_val;
			mem[base + 3] = stim[i].op;
			mem[base + 4] = stim[i].b_val;
			mem[base + 5] = STA_ZP;
			mem[base + 6] = stim[i].zp;
			mem[base + 7] = PHP;
		end
	endtask

	// Each row writes the STA result and then the PHP status
	always @(negedge sys) begin : write_monitor
		int row;
		row = n_writes / 2;
		if (rst) begin
			check_bit("we", we, 1'b0);
			check_bit("oe", oe, 1'b0);
			check_bit("sync", sync, 1'b0);
		end else if (we && n_writes < 2 * ROWS) begin
			if (n_writes % 2 == 0) begin
				check_addr("addr", addr, {8'h00, stim[row].zp});
				check_data("wdata", wdata, stim[row].exp_acc);
			end else begin
				check_addr("addr", addr, {`STACK_PAGE, 8'(`SP_RESET - row)});
				check_data("wdata", wdata, stim[row].exp_p);
			end
			n_writes++;
		end
	end

	// A failed bus assertion ends the run at the next falling edge
	always @(negedge sys) begin
		if (i_cpu_core.i_cpu_core_sva.fail_count != 0) begin
			$display("Bus protocol assertion failed in the bound checker");
			abort_run();
		end
	end

	always @(posedge sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: %0d of %0d writes seen after %0d cycles",
				n_writes, 2 * ROWS, cycles);
			abort_run();
		end
	end

	initial begin
		seed = 32'hf492_4f6f;
		model_p = 8'h00;
		model_p[`STATUS_R] = 1'b1;
		build_table();
		for (int i = 0; i < ROWS; i++)
			predict_row(i);
		load_program();
		// First cycle out of reset fetches at the start address
		@(negedge rst);
		@(negedge sys);
		check_bit("sync", sync, 1'b1);
		check_addr("addr", addr, `START_ADDR);
		while (n_writes < 2 * ROWS)
			@(posedge sys);
		// Let the bound checker finish its last evaluation
		@(negedge sys);
		if (i_cpu_core.i_cpu_core_sva.fail_count != 0) begin
			$display("Bus protocol assertion failed in the bound checker");
			abort_run();
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- vlog.f
+incdir+common
common/cpu_isa_pkg.sv
common/cpu_ctrl_pkg.sv
datapath/alu.sv
datapath/datapath.sv
sequencer/sequencer.sv
hdl/address_unit.sv
hdl/cpu_core.sv
sim/tb_clock.sv
sim/cpu_core_sva.sv
sim/tb_cpu_core.sv
